//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_periph_bus
RTL_TOP   ?= periph_bus
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) src/soc_pkg.sv src/data_ram.sv \
		src/instr_ram.sv src/timer.sv src/gpio.sv src/periph_bus.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
src/soc_pkg.sv
src/data_ram.sv
src/instr_ram.sv
src/timer.sv
src/gpio.sv
src/periph_bus.sv
verification/tb_periph_bus.sv

//--- src/data_ram.sv
module data_ram (
    input  logic                        clk_i,
    input  logic                        we_i,
    input  logic [3:0]                  be_i,
    input  logic [soc_pkg::RAM_AW-1:0]  addr_i,
    input  logic [soc_pkg::DATA_W-1:0]  wdata_i,
    output logic [soc_pkg::DATA_W-1:0]  rdata_o
);
    import soc_pkg::*;

    logic [DATA_W-1:0] mem [RAM_WORDS];

    // byte lane writes.
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    assign rdata_o = mem[addr_i];  // combinational read.

endmodule

//--- src/gpio.sv
module gpio (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        we_i,
    input  logic [1:0]                  be_i,
    input  soc_pkg::gpio_reg_e          reg_i,
    input  logic [soc_pkg::GPIO_W-1:0]  wdata_i,
    output logic [soc_pkg::DATA_W-1:0]  rdata_o,
    input  logic [soc_pkg::GPIO_W-1:0]  pins_i,
    output logic [soc_pkg::GPIO_W-1:0]  pins_o
);
    import soc_pkg::*;

    logic [GPIO_W-1:0] out_q;
    logic [GPIO_W-1:0] in_meta_q;
    logic [GPIO_W-1:0] in_sync_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_q <= '0;
        end else if (we_i && reg_i == GPIO_OUT) begin
            for (int b = 0; b < 2; b++) begin
                if (be_i[b]) begin
                    out_q[8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // two flop input sync.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            in_meta_q <= pins_i;
            in_sync_q <= in_meta_q;
        end
    end

    always_comb begin
        case (reg_i)
            GPIO_OUT: rdata_o = {{(DATA_W-GPIO_W){1'b0}}, out_q};
            GPIO_IN:  rdata_o = {{(DATA_W-GPIO_W){1'b0}}, in_sync_q};
            default:  rdata_o = '0;  // reserved.
        endcase
    end

    assign pins_o = out_q;

endmodule

//--- src/instr_ram.sv
module instr_ram (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    // fetch side.
    input  logic                        fetch_req_i,
    input  logic [soc_pkg::RAM_AW-1:0]  fetch_addr_i,
    output logic                        fetch_gnt_o,
    output logic                        fetch_rvalid_o,
    output logic [soc_pkg::DATA_W-1:0]  fetch_rdata_o,

    // load side from the data port.
    input  logic                        we_i,
    input  logic [3:0]                  be_i,
    input  logic [soc_pkg::RAM_AW-1:0]  waddr_i,
    input  logic [soc_pkg::DATA_W-1:0]  wdata_i
);
    import soc_pkg::*;

    logic [DATA_W-1:0] mem [RAM_WORDS];

    // a data write owns the array this cycle, fetch must wait.
    assign fetch_gnt_o = fetch_req_i & ~we_i;

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // ============================================================
    // synchronous fetch read
    // ============================================================
    always_ff @(posedge clk_i) begin
        if (fetch_gnt_o) begin
            fetch_rdata_o <= mem[fetch_addr_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fetch_rvalid_o <= 1'b0;
        end else begin
            fetch_rvalid_o <= fetch_gnt_o;
        end
    end

    // no fetch data without a grant the cycle before.
    a_rvalid_after_gnt: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        fetch_rvalid_o |-> $past(fetch_gnt_o)
    );

endmodule

//--- src/periph_bus.sv
module periph_bus (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    input  logic                        data_req_i,
    input  logic                        data_we_i,
    input  logic [3:0]                  data_be_i,
    input  logic [soc_pkg::ADDR_W-1:0]  data_addr_i,
    input  logic [soc_pkg::DATA_W-1:0]  data_wdata_i,
    output logic                        data_rvalid_o,
    output logic [soc_pkg::DATA_W-1:0]  data_rdata_o,

    input  logic                        instr_req_i,
    input  logic [soc_pkg::ADDR_W-1:0]  instr_addr_i,
    output logic                        instr_gnt_o,
    output logic                        instr_rvalid_o,
    output logic [soc_pkg::DATA_W-1:0]  instr_rdata_o,

    input  logic [soc_pkg::GPIO_W-1:0]  gpio_i,
    output logic [soc_pkg::GPIO_W-1:0]  gpio_o,

    input  logic                        irq_ack_i,
    output logic                        irq_o
);
    import soc_pkg::*;

    logic              wr;
    logic              dram_sel;
    periph_sel_e       sel;
    logic              dram_we;
    logic              imem_we;
    logic              timer_we;
    logic              gpio_we;
    logic [DATA_W-1:0] dram_rdata;
    logic [DATA_W-1:0] timer_rdata;
    logic [DATA_W-1:0] gpio_rdata;
    logic [DATA_W-1:0] rdata_d;

    // ============================================================
    // address decode
    // ============================================================
    assign wr       = data_req_i & data_we_i;
    assign dram_sel = ~data_addr_i[PERIPH_BIT];
    assign sel      = periph_sel_e'(data_addr_i[SEL_MSB:SEL_LSB]);

    assign dram_we  = wr & dram_sel;
    assign timer_we = wr & ~dram_sel & (sel == SEL_TIMER);
    assign gpio_we  = wr & ~dram_sel & (sel == SEL_GPIO);
    assign imem_we  = wr & ~dram_sel & ((sel == SEL_IMEM_LO) | (sel == SEL_IMEM_HI));

    // ============================================================
    // blocks
    // ============================================================
    data_ram u_data_ram (
        .clk_i   (clk_i),
        .we_i    (dram_we),
        .be_i    (data_be_i),
        .addr_i  (data_addr_i[RAM_AW+1:2]),
        .wdata_i (data_wdata_i),
        .rdata_o (dram_rdata)
    );

    instr_ram u_instr_ram (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .fetch_req_i    (instr_req_i),
        .fetch_addr_i   (instr_addr_i[RAM_AW+1:2]),
        .fetch_gnt_o    (instr_gnt_o),
        .fetch_rvalid_o (instr_rvalid_o),
        .fetch_rdata_o  (instr_rdata_o),
        .we_i           (imem_we),
        .be_i           (data_be_i),
        .waddr_i        (data_addr_i[RAM_AW+1:2]),
        .wdata_i        (data_wdata_i)
    );

    timer u_timer (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .we_i      (timer_we),
        .be_i      (data_be_i),
        .reg_i     (timer_reg_e'(data_addr_i[REG_MSB:REG_LSB])),
        .wdata_i   (data_wdata_i),
        .rdata_o   (timer_rdata),
        .irq_ack_i (irq_ack_i),
        .irq_o     (irq_o)
    );

    gpio u_gpio (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (gpio_we),
        .be_i    (data_be_i[1:0]),
        .reg_i   (gpio_reg_e'(data_addr_i[REG_MSB:REG_LSB])),
        .wdata_i (data_wdata_i[GPIO_W-1:0]),
        .rdata_o (gpio_rdata),
        .pins_i  (gpio_i),
        .pins_o  (gpio_o)
    );

    // ============================================================
    // read response
    // ============================================================
    always_comb begin
        rdata_d = '0;  // unmapped and imem window read zero.
        if (dram_sel) begin
            rdata_d = dram_rdata;
        end else begin
            case (sel)
                SEL_TIMER: rdata_d = timer_rdata;
                SEL_GPIO:  rdata_d = gpio_rdata;
                default:   rdata_d = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_rvalid_o <= 1'b0;
        end else begin
            data_rvalid_o <= data_req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        data_rdata_o <= rdata_d;  // value seen before this cycle's write.
    end

    // a response never appears without a request one cycle earlier.
    a_rvalid_after_req: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        data_rvalid_o |-> $past(data_req_i)
    );

endmodule

//--- src/soc_pkg.sv
package soc_pkg;

    // ============================================================
    // bus widths and memory sizes
    // ============================================================
    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW    = 10;   // word index, addr bits 11:2.
    localparam int GPIO_W    = 16;

    // ============================================================
    // address map
    // ============================================================
    localparam int PERIPH_BIT = 16;  // low selects data ram.
    localparam int SEL_MSB    = 15;
    localparam int SEL_LSB    = 13;
    localparam int REG_MSB    = 3;   // register offset inside a block.
    localparam int REG_LSB    = 2;

    // peripheral select, addr bits 15:13.
    typedef enum logic [2:0] {
        SEL_UART    = 3'd0,
        SEL_I2C     = 3'd1,
        SEL_QSPI    = 3'd2,
        SEL_TIMER   = 3'd3,
        SEL_USB     = 3'd4,
        SEL_GPIO    = 3'd5,
        SEL_IMEM_LO = 3'd6,
        SEL_IMEM_HI = 3'd7
    } periph_sel_e;

    // ============================================================
    // register offsets
    // ============================================================
    typedef enum logic [1:0] {
        TMR_CTRL    = 2'd0,
        TMR_COUNT   = 2'd1,
        TMR_COMPARE = 2'd2,
        TMR_STATUS  = 2'd3
    } timer_reg_e;

    localparam int TMR_EN_BIT   = 0;
    localparam int TMR_IE_BIT   = 1;
    localparam int TMR_PEND_BIT = 0;  // write 1 clears.

    typedef enum logic [1:0] {
        GPIO_OUT   = 2'd0,
        GPIO_IN    = 2'd1,
        GPIO_RSVD2 = 2'd2,
        GPIO_RSVD3 = 2'd3
    } gpio_reg_e;

endpackage

//--- src/timer.sv
module timer (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        we_i,
    input  logic [3:0]                  be_i,
    input  soc_pkg::timer_reg_e         reg_i,
    input  logic [soc_pkg::DATA_W-1:0]  wdata_i,
    output logic [soc_pkg::DATA_W-1:0]  rdata_o,
    input  logic                        irq_ack_i,
    output logic                        irq_o
);
    import soc_pkg::*;

    logic [1:0]        ctrl_q;   // bit 0 enable, bit 1 irq enable.
    logic [DATA_W-1:0] count_q;
    logic [DATA_W-1:0] compare_q;
    logic              pending_q;
    logic              match;
    logic              pend_clr;

    function automatic logic [DATA_W-1:0] merge_be(
        input logic [DATA_W-1:0] old_v,
        input logic [DATA_W-1:0] new_v,
        input logic [3:0]        be
    );
        logic [DATA_W-1:0] res;
        res = old_v;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_v[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign match    = ctrl_q[TMR_EN_BIT] & (count_q == compare_q);
    assign pend_clr = irq_ack_i
                    | (we_i & (reg_i == TMR_STATUS) & be_i[0] & wdata_i[TMR_PEND_BIT]);

    // ============================================================
    // registers
    // ============================================================
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctrl_q    <= '0;
            count_q   <= '0;
            compare_q <= '0;
            pending_q <= 1'b0;
        end else begin
            if (we_i && reg_i == TMR_CTRL && be_i[0]) begin
                ctrl_q <= wdata_i[1:0];
            end
            if (we_i && reg_i == TMR_COMPARE) begin
                compare_q <= merge_be(compare_q, wdata_i, be_i);
            end
            // bus write beats the running count.
            if (we_i && reg_i == TMR_COUNT) begin
                count_q <= merge_be(count_q, wdata_i, be_i);
            end else if (match) begin
                count_q <= '0;
            end else if (ctrl_q[TMR_EN_BIT]) begin
                count_q <= count_q + DATA_W'(1);
            end
            pending_q <= (pending_q & ~pend_clr) | match;  // new match wins.
        end
    end

    always_comb begin
        case (reg_i)
            TMR_CTRL:    rdata_o = {{(DATA_W-2){1'b0}}, ctrl_q};
            TMR_COUNT:   rdata_o = count_q;
            TMR_COMPARE: rdata_o = compare_q;
            default:     rdata_o = {{(DATA_W-1){1'b0}}, pending_q};
        endcase
    end

    assign irq_o = pending_q & ctrl_q[TMR_IE_BIT];

    a_irq_needs_pending: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        irq_o |-> pending_q
    );

endmodule

//--- verification/tb_periph_bus.sv
module tb_periph_bus;
    import soc_pkg::*;

    localparam int N_RAM   = 400;
    localparam int N_MAP   = 40;
    localparam int N_FETCH = 300;
    localparam int N_GPIO  = 24;
    localparam int N_TMR   = 3 + 2 * (40 + 16);
    // upper bound of all phases in cycles.
    localparam int TEST_CYCLES = 16 + 2 * RAM_WORDS + 2 * N_RAM + 3 * N_MAP
                               + N_FETCH + 7 * N_GPIO + N_TMR + 8;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic        clk;
    logic        rst_n;
    logic        data_req;
    logic        data_we;
    logic [3:0]  data_be;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic        data_rvalid;
    logic [31:0] data_rdata;
    logic        instr_req;
    logic [31:0] instr_addr;
    logic        instr_gnt;
    logic        instr_rvalid;
    logic [31:0] instr_rdata;
    logic [15:0] gpio_in;
    logic [15:0] gpio_out;
    logic        irq_ack;
    logic        irq;

    logic [31:0] dram_m [RAM_WORDS];
    bit          dram_known [RAM_WORDS];  // ram is not reset.
    logic [31:0] imem_m [RAM_WORDS];
    logic [15:0] gpio_out_m = '0;
    logic [15:0] gpio_shadow;
    logic [31:0] ctrl_m = '0;
    logic [31:0] cmp_m = '0;
    logic [31:0] data_q [$];
    bit          data_chk_q [$];
    logic [31:0] fetch_q [$];
    logic        exp_gnt = 1'b0;
    logic        req_prev = 1'b0;
    logic        gnt_prev = 1'b0;
    int          errors = 0;
    int          n_checks = 0;
    int          cycles = 0;

    periph_bus DUT (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .data_req_i     (data_req),
        .data_we_i      (data_we),
        .data_be_i      (data_be),
        .data_addr_i    (data_addr),
        .data_wdata_i   (data_wdata),
        .data_rvalid_o  (data_rvalid),
        .data_rdata_o   (data_rdata),
        .instr_req_i    (instr_req),
        .instr_addr_i   (instr_addr),
        .instr_gnt_o    (instr_gnt),
        .instr_rvalid_o (instr_rvalid),
        .instr_rdata_o  (instr_rdata),
        .gpio_i         (gpio_in),
        .gpio_o         (gpio_out),
        .irq_ack_i      (irq_ack),
        .irq_o          (irq)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // ============================================================
    // model helpers
    // ============================================================
    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] byte_merge(input logic [31:0] old_v,
                                               input logic [31:0] new_v,
                                               input logic [3:0]  be);
        logic [31:0] res;
        res = old_v;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_v[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [31:0] periph_addr(input logic [2:0] sel, input logic [1:0] rg);
        logic [31:0] a;
        a         = $urandom();  // don't-care bits stay random.
        a[16]     = 1'b1;
        a[15:13]  = sel;
        a[3:2]    = rg;
        a[1:0]    = 2'b00;
        return a;
    endfunction

    function automatic logic [31:0] imem_addr(input int idx);
        logic [31:0] a;
        a       = periph_addr(($urandom_range(0, 1) == 1) ? SEL_IMEM_HI : SEL_IMEM_LO, 2'b00);
        a[11:2] = 10'(idx);
        return a;
    endfunction

    // timer registers are tracked by the timer runs themselves.
    function automatic logic [31:0] model_read(input logic [31:0] addr);
        if (!addr[16]) begin
            return dram_m[addr[11:2]];
        end
        if (addr[15:13] == SEL_GPIO && addr[3:2] == GPIO_OUT) begin
            return {16'h0, gpio_out_m};
        end
        if (addr[15:13] == SEL_GPIO && addr[3:2] == GPIO_IN) begin
            return {16'h0, gpio_in};
        end
        return 32'h0;  // unmapped, imem window, reserved.
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [3:0] be,
                                        input logic [31:0] wdata);
        logic [31:0] tmp;
        if (!addr[16]) begin
            dram_m[addr[11:2]] = byte_merge(dram_m[addr[11:2]], wdata, be);
            if (be == 4'hf) begin
                dram_known[addr[11:2]] = 1'b1;
            end
        end else if (addr[15:13] == SEL_IMEM_LO || addr[15:13] == SEL_IMEM_HI) begin
            imem_m[addr[11:2]] = byte_merge(imem_m[addr[11:2]], wdata, be);
        end else if (addr[15:13] == SEL_GPIO && addr[3:2] == GPIO_OUT) begin
            tmp        = byte_merge({16'h0, gpio_out_m}, wdata, {2'b00, be[1:0]});
            gpio_out_m = tmp[15:0];
        end
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic data_idle();
        data_req = 1'b0;
        data_we  = 1'b0;
    endtask

    task automatic drive_data(input logic we, input logic [3:0] be, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [31:0] exp, input bit chk);
        data_req   = 1'b1;
        data_we    = we;
        data_be    = be;
        data_addr  = addr;
        data_wdata = wdata;
        data_q.push_back(exp);  // value before this request's write.
        data_chk_q.push_back(chk);
        if (we) begin
            model_write(addr, be, wdata);
        end
    endtask

    task automatic access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [31:0] exp, input bit chk);
        drive_data(we, be, addr, wdata, exp, chk);
        step();
    endtask

    // ============================================================
    // test phases
    // ============================================================
    task automatic random_ram_access();
        logic [31:0] addr;
        for (int i = 0; i < RAM_WORDS; i++) begin
            addr = {12'h0, 4'($urandom_range(0, 15)), 16'h0} | (32'(i) << 2);
            addr[16] = 1'b0;
            access(1'b1, 4'hf, addr, $urandom(), 32'h0, 1'b0);
        end
        for (int i = 0; i < N_RAM; i++) begin
            addr = $urandom() & ~32'h1_0003;  // upper bits wrap.
            access($urandom_range(0, 1) == 1, 4'($urandom_range(1, 15)), addr, $urandom(),
                   model_read(addr), dram_known[addr[11:2]]);
            if ($urandom_range(0, 3) == 0) begin
                data_idle();
                step();
            end
        end
        data_idle();
    endtask

    task automatic unmapped_access();
        logic [31:0] addr;
        logic [31:0] raddr;
        logic [2:0]  sel;
        for (int i = 0; i < N_MAP; i++) begin
            sel = 3'($urandom_range(0, 7));
            if (sel == SEL_TIMER || sel == SEL_GPIO) begin
                sel = SEL_USB;
            end
            addr  = periph_addr(sel, 2'($urandom_range(0, 3)));
            raddr = addr & ~32'h1_0000;  // same word in the data ram.
            access(1'b1, 4'($urandom_range(1, 15)), addr, $urandom(), model_read(addr), 1'b1);
            access(1'b0, 4'hf, addr, 32'h0, model_read(addr), 1'b1);
            access(1'b0, 4'hf, raddr, 32'h0, model_read(raddr), 1'b1);
        end
        data_idle();
    endtask

    task automatic fetch_while_loading();
        logic [31:0] addr;
        logic        hold;
        logic        win_wr;
        for (int i = 0; i < RAM_WORDS; i++) begin
            access(1'b1, 4'hf, imem_addr(i), $urandom(), 32'h0, 1'b1);
        end
        hold = 1'b0;
        for (int i = 0; i < N_FETCH; i++) begin
            if (!hold) begin
                instr_req  = ($urandom_range(0, 3) != 0);
                instr_addr = $urandom() & ~32'h3;
            end
            win_wr  = ($urandom_range(0, 2) == 0);
            exp_gnt = instr_req & ~win_wr;  // a window write takes the array.
            if (exp_gnt) begin
                fetch_q.push_back(imem_m[instr_addr[11:2]]);
            end
            if (win_wr) begin
                addr = imem_addr($urandom_range(0, RAM_WORDS - 1));
                drive_data(1'b1, 4'($urandom_range(1, 15)), addr, $urandom(), 32'h0, 1'b1);
            end else begin
                data_idle();
            end
            hold = instr_req & ~exp_gnt;  // refused fetch is held.
            step();
        end
        instr_req = 1'b0;
        exp_gnt   = 1'b0;
        data_idle();
    endtask

    task automatic exercise_gpio();
        logic [31:0] addr;
        for (int i = 0; i < N_GPIO; i++) begin
            addr = periph_addr(SEL_GPIO, GPIO_OUT);
            access(1'b1, 4'($urandom_range(0, 15)), addr, $urandom(), model_read(addr), 1'b1);
            access(1'b0, 4'hf, addr, 32'h0, model_read(addr), 1'b1);
            data_idle();
            gpio_in = 16'($urandom());
            repeat (3) step();  // two sync flops plus margin.
            addr = periph_addr(SEL_GPIO, GPIO_IN);
            access(1'b0, 4'hf, addr, 32'h0, model_read(addr), 1'b1);
            addr = periph_addr(SEL_GPIO, 2'($urandom_range(2, 3)));
            access(1'b0, 4'hf, addr, 32'h0, 32'h0, 1'b1);
        end
        data_idle();
    endtask

    task automatic timer_compare_run(input logic ie);
        logic [31:0] cmp;
        logic [31:0] ctrl_on;
        logic [31:0] ctrl_off;
        cmp      = 32'($urandom_range(4, 40));
        ctrl_on  = {30'h0, ie, 1'b1};
        ctrl_off = {30'h0, ie, 1'b0};
        // count left over from an earlier run.
        access(1'b1, 4'hf, periph_addr(SEL_TIMER, TMR_COUNT), 32'h0, 32'h0, 1'b0);
        access(1'b1, 4'hf, periph_addr(SEL_TIMER, TMR_COMPARE), cmp, cmp_m, 1'b1);
        cmp_m = cmp;
        access(1'b1, 4'hf, periph_addr(SEL_TIMER, TMR_CTRL), ctrl_on, ctrl_m, 1'b1);
        ctrl_m = ctrl_on;
        data_idle();
        for (int k = 0; k < int'(cmp) + 5; k++) begin
            step();
            if (!ie) begin
                check(32'(irq), 32'h0, "irq_o with interrupt masked");
            end
        end
        access(1'b0, 4'hf, periph_addr(SEL_TIMER, TMR_STATUS), 32'h0, 32'h1, 1'b1);
        check(32'(irq), 32'(ie), "irq_o while pending");
        // stop counting so no new match meets the clear.
        access(1'b1, 4'hf, periph_addr(SEL_TIMER, TMR_CTRL), ctrl_off, ctrl_m, 1'b1);
        ctrl_m = ctrl_off;
        if (ie) begin
            data_idle();
            irq_ack = 1'b1;
            step();
            irq_ack = 1'b0;
        end else begin
            access(1'b1, 4'h1, periph_addr(SEL_TIMER, TMR_STATUS), 32'h1, 32'h1, 1'b1);
        end
        access(1'b0, 4'hf, periph_addr(SEL_TIMER, TMR_STATUS), 32'h0, 32'h0, 1'b1);
        check(32'(irq), 32'h0, "irq_o after clear");
        data_idle();
    endtask

    // ============================================================
    // response monitor, outputs settled at the falling edge
    // ============================================================
    always @(posedge clk) begin
        gpio_shadow <= gpio_out_m;
    end

    always @(negedge clk) begin
        logic [31:0] exp_v;
        bit          chk_v;
        if (data_rvalid && !req_prev) begin
            errors++;
            $display("data_rvalid_o at %0t came without a request one cycle before", $time);
        end else if (!data_rvalid && req_prev) begin
            errors++;
            $display("data_rvalid_o missing at %0t one cycle after a request", $time);
            if (data_q.size() != 0) begin
                void'(data_q.pop_front());
                void'(data_chk_q.pop_front());
            end
        end else if (data_rvalid && data_q.size() != 0) begin
            exp_v = data_q.pop_front();
            chk_v = data_chk_q.pop_front();
            if (chk_v) begin
                check(data_rdata, exp_v, "data_rdata_o");
            end
        end
        req_prev = data_req;
        check(32'(instr_gnt), 32'(exp_gnt), "instr_gnt_o");
        if (instr_rvalid && !gnt_prev) begin
            errors++;
            $display("instr_rvalid_o at %0t came without a grant one cycle before", $time);
        end else if (!instr_rvalid && gnt_prev) begin
            errors++;
            $display("instr_rvalid_o missing at %0t one cycle after a grant", $time);
            if (fetch_q.size() != 0) begin
                void'(fetch_q.pop_front());
            end
        end else if (instr_rvalid && fetch_q.size() != 0) begin
            check(instr_rdata, fetch_q.pop_front(), "instr_rdata_o");
        end
        gnt_prev = exp_gnt;
        check(32'(gpio_out), 32'(gpio_shadow), "gpio_o");
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        void'($urandom(32'h34c2));
        rst_n      = 1'b0;
        data_req   = 1'b0;
        data_we    = 1'b0;
        data_be    = 4'h0;
        data_addr  = 32'h0;
        data_wdata = 32'h0;
        instr_req  = 1'b0;
        instr_addr = 32'h0;
        gpio_in    = 16'h0;
        irq_ack    = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check(32'(irq), 32'h0, "irq_o after reset");
        random_ram_access();
        unmapped_access();
        fetch_while_loading();
        exercise_gpio();
        access(1'b0, 4'hf, periph_addr(SEL_TIMER, TMR_CTRL), 32'h0, 32'h0, 1'b1);
        access(1'b0, 4'hf, periph_addr(SEL_TIMER, TMR_COMPARE), 32'h0, 32'h0, 1'b1);
        access(1'b0, 4'hf, periph_addr(SEL_TIMER, TMR_STATUS), 32'h0, 32'h0, 1'b1);
        timer_compare_run(1'b1);
        timer_compare_run(1'b0);
        data_idle();
        repeat (2) step();
        if (data_q.size() != 0 || fetch_q.size() != 0) begin
            errors++;
            $display("responses still outstanding at the end: %0d data, %0d fetch",
                     data_q.size(), fetch_q.size());
        end
        $display("checks: %0d, errors: %0d", n_checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
